// ==== source/game_pkg.sv ====
// Platform game shared definitions
package game_pkg;

    // ------------------------------
    // screen and physics constants
    // ------------------------------
    localparam int SCREEN_W    = 1024;
    // lowest foot row on screen
    localparam int FLOOR_Y     = 767;
    localparam int PLAYER_W    = 32;
    localparam int PLAYER_H    = 48;
    localparam int JUMP_HEIGHT = 40;
    localparam int SPAWN_X0    = 100;
    localparam int SPAWN_GAP   = 300;
    localparam int SPAWN_Y     = FLOOR_Y - PLAYER_H;
    // rightmost legal left edge
    localparam int X_LIMIT     = SCREEN_W - PLAYER_W;

    // single platform away from the spawn columns
    localparam int PLATFORM_X_MIN = 600;
    localparam int PLATFORM_X_MAX = 760;
    // top row within jump reach of the floor
    localparam int PLATFORM_Y     = 740;

    // ------------------------------
    // types
    // ------------------------------
    // y grows downward from the top left of the sprite box
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pos_t;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } move_cmd_t;

    typedef struct packed {
        logic       facing_right;
        logic       airborne;
        logic       idle;
        logic [3:0] frame;
    } sprite_ctrl_t;

    typedef enum logic [1:0] {
        move_idle = 2'b00,
        move_walk = 2'b01,
        move_jump = 2'b11,
        move_fall = 2'b10
    } move_state_t;

    // standing still and looking right
    localparam sprite_ctrl_t SPRITE_SPAWN = '{
        facing_right: 1'b1,
        airborne:     1'b0,
        idle:         1'b1,
        frame:        4'd0
    };

    // foot row resting on the floor or on the platform top
    function automatic logic landed(input logic [9:0] x, input logic [9:0] foot);
        logic on_floor;
        logic over_platform;
        on_floor      = (foot == 10'(FLOOR_Y));
        over_platform = (x + PLAYER_W > PLATFORM_X_MIN) && (x < PLATFORM_X_MAX);
        return on_floor || (over_platform && (foot == 10'(PLATFORM_Y)));
    endfunction

endpackage

// ==== source/game_top.sv ====
// Platform game movement core
`timescale 1ns/1ns

module game_top #(
    parameter int N_PLAYERS = 2,
    parameter int TICK_DIV  = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   restart,
    input  game_pkg::move_cmd_t    [N_PLAYERS-1:0] buttons,
    output game_pkg::pos_t         [N_PLAYERS-1:0] pos,
    output game_pkg::sprite_ctrl_t [N_PLAYERS-1:0] sprite,
    output logic                                   game_over
);

    game_pkg::move_cmd_t [N_PLAYERS-1:0] cmd;
    logic                                step_tick;

    input_conditioner #(
        .N_PLAYERS (N_PLAYERS),
        .TICK_DIV  (TICK_DIV)
    ) u_input_conditioner (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .cmd       (cmd),
        .step_tick (step_tick)
    );

    // one controller per player
    for (genvar i = 0; i < N_PLAYERS; i++) begin : g_player
        player_move_ctrl #(
            .PLAYER_ID (i)
        ) u_player_move_ctrl (
            .clk       (clk),
            .rst       (rst),
            .restart   (restart),
            .game_over (game_over),
            .step_tick (step_tick),
            .cmd       (cmd[i]),
            .pos       (pos[i]),
            .sprite    (sprite[i])
        );
    end

    scene_collector #(
        .N_PLAYERS (N_PLAYERS)
    ) u_scene_collector (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .pos       (pos),
        .game_over (game_over)
    );

endmodule

// ==== source/input_conditioner.sv ====
// Button conditioner and step tick
`timescale 1ns/1ns

module input_conditioner #(
    parameter int N_PLAYERS = 2,
    parameter int TICK_DIV  = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  game_pkg::move_cmd_t [N_PLAYERS-1:0]   buttons,
    output game_pkg::move_cmd_t [N_PLAYERS-1:0]   cmd,
    output logic                                  step_tick
);

    localparam int CNT_W = (TICK_DIV > 2) ? $clog2(TICK_DIV) : 1;

    game_pkg::move_cmd_t [N_PLAYERS-1:0] clean;
    logic [CNT_W-1:0]                    tick_cnt;
    logic                                tick_wrap;

    // ------------------------------
    // direction conflict
    // ------------------------------
    always_comb begin
        for (int i = 0; i < N_PLAYERS; i++) begin
            clean[i] = buttons[i];
            // both directions cancel, jump still passes
            if (buttons[i].left && buttons[i].right) begin
                clean[i].left  = 1'b0;
                clean[i].right = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd <= clean;
        end
    end

    // ------------------------------
    // tick prescaler
    // ------------------------------
    assign tick_wrap = (tick_cnt == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt  <= '0;
            step_tick <= 1'b0;
        end else begin
            step_tick <= tick_wrap;
            if (tick_wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // controllers rely on one move per tick
    a_tick_single: assert property (
        @(posedge clk) disable iff (rst) step_tick |=> !step_tick
    ) else $error("step_tick high on two consecutive cycles");

endmodule

// ==== source/player_move_ctrl.sv ====
// Player movement controller
`timescale 1ns/1ns

module player_move_ctrl #(
    parameter int PLAYER_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   restart,
    input  logic                   game_over,
    input  logic                   step_tick,
    input  game_pkg::move_cmd_t    cmd,
    output game_pkg::pos_t         pos,
    output game_pkg::sprite_ctrl_t sprite
);

    localparam logic [9:0] SPAWN_X =
        10'(game_pkg::SPAWN_X0 + PLAYER_ID * game_pkg::SPAWN_GAP);
    localparam logic [9:0] SPAWN_Y = 10'(game_pkg::SPAWN_Y);

    game_pkg::move_state_t  state;
    game_pkg::move_state_t  state_nxt;
    game_pkg::pos_t         pos_nxt;
    game_pkg::sprite_ctrl_t sprite_nxt;
    logic                   air_parity;
    logic                   parity_nxt;
    logic [9:0]             jump_start;
    logic [9:0]             x_step;
    logic [9:0]             foot_now;
    logic                   x_moved;

    assign foot_now = pos.y + 10'(game_pkg::PLAYER_H);

    // clamped candidate x for this tick
    always_comb begin
        x_step = pos.x;
        if (cmd.right && (pos.x < 10'(game_pkg::X_LIMIT))) begin
            x_step = pos.x + 10'd1;
        end else if (cmd.left && (pos.x > 10'd0)) begin
            x_step = pos.x - 10'd1;
        end
    end

    // ------------------------------
    // next state and position
    // ------------------------------
    always_comb begin
        state_nxt  = state;
        pos_nxt    = pos;
        parity_nxt = 1'b0;
        case (state)
            game_pkg::move_idle: begin
                if (cmd.jump) begin
                    state_nxt = game_pkg::move_jump;
                end else if (cmd.left || cmd.right) begin
                    state_nxt = game_pkg::move_walk;
                end
            end
            game_pkg::move_walk: begin
                if (cmd.jump) begin
                    state_nxt = game_pkg::move_jump;
                end else if (cmd.left || cmd.right) begin
                    pos_nxt.x = x_step;
                    // walked off the platform edge
                    if (!game_pkg::landed(x_step, foot_now)) begin
                        state_nxt = game_pkg::move_fall;
                    end
                end else begin
                    state_nxt = game_pkg::move_idle;
                end
            end
            game_pkg::move_jump: begin
                // half rate in the air
                parity_nxt = ~air_parity;
                if (air_parity) begin
                    pos_nxt.x = x_step;
                end
                pos_nxt.y = pos.y - 10'd1;
                if ((jump_start - pos_nxt.y) >= 10'(game_pkg::JUMP_HEIGHT)) begin
                    state_nxt = game_pkg::move_fall;
                end
            end
            game_pkg::move_fall: begin
                parity_nxt = ~air_parity;
                if (air_parity) begin
                    pos_nxt.x = x_step;
                end
                pos_nxt.y = pos.y + 10'd1;
                if (game_pkg::landed(pos_nxt.x, pos_nxt.y + 10'(game_pkg::PLAYER_H))) begin
                    state_nxt = game_pkg::move_idle;
                end
            end
            default: begin
                state_nxt = game_pkg::move_idle;
            end
        endcase
    end

    // ------------------------------
    // sprite control word
    // ------------------------------
    assign x_moved = (pos_nxt.x != pos.x);

    always_comb begin
        sprite_nxt = sprite;
        if (cmd.right) begin
            sprite_nxt.facing_right = 1'b1;
        end else if (cmd.left) begin
            sprite_nxt.facing_right = 1'b0;
        end
        sprite_nxt.airborne = (state_nxt == game_pkg::move_jump) ||
                              (state_nxt == game_pkg::move_fall);
        sprite_nxt.idle     = (state_nxt == game_pkg::move_idle);
        // animation steps every 8 pixels of travel
        if (x_moved && (pos_nxt.x[2:0] == 3'd0)) begin
            sprite_nxt.frame = {1'b0, sprite.frame[2:0] + 3'd1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state      <= game_pkg::move_idle;
            pos.x      <= SPAWN_X;
            pos.y      <= SPAWN_Y;
            sprite     <= game_pkg::SPRITE_SPAWN;
            air_parity <= 1'b0;
        end else if (step_tick && !game_over) begin
            state      <= state_nxt;
            pos        <= pos_nxt;
            sprite     <= sprite_nxt;
            air_parity <= parity_nxt;
        end
    end

    // take-off row follows y while grounded
    always_ff @(posedge clk) begin
        if ((state == game_pkg::move_idle) || (state == game_pkg::move_walk)) begin
            jump_start <= pos.y;
        end
    end

    a_jump_apex: assert property (
        @(posedge clk) disable iff (rst)
        ((state == game_pkg::move_jump) || (state == game_pkg::move_fall)) |->
            (pos.y + game_pkg::JUMP_HEIGHT >= jump_start)
    ) else $error("player %0d rose above jump height", PLAYER_ID);

    a_x_bounds: assert property (
        @(posedge clk) disable iff (rst) pos.x <= 10'(game_pkg::X_LIMIT)
    ) else $error("player %0d x out of screen", PLAYER_ID);

endmodule

// ==== source/scene_collector.sv ====
// Scene collector with overlap detection
`timescale 1ns/1ns

module scene_collector #(
    parameter int N_PLAYERS = 2
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             restart,
    input  game_pkg::pos_t [N_PLAYERS-1:0]   pos,
    output logic                             game_over
);

    logic overlap;

    // boxes share at least one pixel
    function automatic logic boxes_touch(input game_pkg::pos_t a, input game_pkg::pos_t b);
        logic x_hit;
        logic y_hit;
        x_hit = (a.x < b.x + game_pkg::PLAYER_W) && (b.x < a.x + game_pkg::PLAYER_W);
        y_hit = (a.y < b.y + game_pkg::PLAYER_H) && (b.y < a.y + game_pkg::PLAYER_H);
        return x_hit && y_hit;
    endfunction

    // ------------------------------
    // pairwise check
    // ------------------------------
    always_comb begin
        overlap = 1'b0;
        for (int i = 0; i < N_PLAYERS; i++) begin
            for (int j = i + 1; j < N_PLAYERS; j++) begin
                if (boxes_touch(pos[i], pos[j])) begin
                    overlap = 1'b1;
                end
            end
        end
    end

    // latch holds until restart
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            game_over <= 1'b0;
        end else if (overlap) begin
            game_over <= 1'b1;
        end
    end

    a_over_hold: assert property (
        @(posedge clk) disable iff (rst) $fell(game_over) |-> $past(restart)
    ) else $error("game_over cleared without restart");

endmodule

// ==== tests/game_tb.sv ====
// Platform game core testbench
`timescale 1ns/1ns

module game_tb;

    localparam int N_PLAYERS    = 2;
    localparam int TICK_DIV     = 4;
    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 10;

    // test lengths in step ticks
    localparam int WALK_K        = 16;
    localparam int WALK_TICKS    = WALK_K + 8;
    localparam int LEFT_TICKS    = 160;
    localparam int WALL_TICKS    = 8;
    localparam int JUMP_TICKS    = 2 * game_pkg::JUMP_HEIGHT + 8;
    localparam int CRASH_TICKS   = game_pkg::SPAWN_GAP + 8;
    localparam int FREEZE_TICKS  = 12;
    localparam int TOTAL_TICKS   = WALK_TICKS + LEFT_TICKS + WALL_TICKS + JUMP_TICKS +
                                   CRASH_TICKS + FREEZE_TICKS;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_NS   =
        (RESET_CYCLES + TOTAL_TICKS * TICK_DIV + MARGIN_CYCLES) * CLK_NS;

    logic                                   clk;
    logic                                   rst;
    logic                                   restart;
    game_pkg::move_cmd_t    [N_PLAYERS-1:0] buttons;
    game_pkg::pos_t         [N_PLAYERS-1:0] pos;
    game_pkg::sprite_ctrl_t [N_PLAYERS-1:0] sprite;
    logic                                   game_over;

    // one check window per behavior
    logic   chk_spawn    = 1'b0;
    logic   chk_right    = 1'b0;
    logic   chk_walk_len = 1'b0;
    logic   chk_wall     = 1'b0;
    logic   chk_both     = 1'b0;
    logic   chk_jump     = 1'b0;
    logic   chk_land     = 1'b0;
    logic   chk_crash    = 1'b0;
    logic   chk_respawn  = 1'b0;
    int     walk_x0      = 0;
    int     apex_y       = 0;
    int     err_cnt      = 0;
    int     test_cnt     = 0;
    int     fail_cnt     = 0;
    integer seed;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clock_gen (.clk(clk));

    game_top #(
        .N_PLAYERS (N_PLAYERS),
        .TICK_DIV  (TICK_DIV)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .buttons   (buttons),
        .pos       (pos),
        .sprite    (sprite),
        .game_over (game_over)
    );

    task automatic log_error(input string msg);
        err_cnt++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    // spawn column grows with the player index
    function automatic bit players_at_spawn(input game_pkg::pos_t [N_PLAYERS-1:0] p);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < N_PLAYERS; i++) begin
            if ((p[i].x != game_pkg::SPAWN_X0 + i * game_pkg::SPAWN_GAP) ||
                (p[i].y != game_pkg::SPAWN_Y)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // ------------------------------
    // checking assertions
    // ------------------------------
    a_spawn: assert property (@(posedge clk) chk_spawn |->
        players_at_spawn(pos) && !game_over &&
        sprite[0].facing_right && sprite[0].idle && (sprite[0].frame == 0) &&
        sprite[1].facing_right && sprite[1].idle && (sprite[1].frame == 0)
    ) else log_error("reset state is not spawn, idle, facing right");

    a_right_step: assert property (@(posedge clk) disable iff (rst) chk_right |->
        (pos[0].x >= $past(pos[0].x)) &&
        (int'(pos[0].x) - int'($past(pos[0].x, TICK_DIV)) <= 1) && sprite[0].facing_right
    ) else log_error("walking right moved backward, too fast or faced left");

    // one frame step per multiple of 8 passed since spawn
    a_walk_len: assert property (@(posedge clk) chk_walk_len |->
        (int'(pos[0].x) >= walk_x0 + WALK_K - 1) &&
        (int'(pos[0].x) <= walk_x0 + WALK_K + 1) &&
        (sprite[0].frame == (int'(pos[0].x) / 8 - game_pkg::SPAWN_X0 / 8) % 8)
    ) else log_error("walk distance or animation frame differs from the tick count");

    a_wall: assert property (@(posedge clk) chk_wall |->
        (pos[0].x == 0) && !sprite[0].facing_right
    ) else log_error("player 0 not held at the left screen edge facing left");

    a_both: assert property (@(posedge clk) disable iff (rst) chk_both |-> $stable(pos[1]))
        else log_error("left and right together moved player 1");

    a_apex: assert property (@(posedge clk) chk_jump |->
        int'(pos[0].y) >= game_pkg::SPAWN_Y - game_pkg::JUMP_HEIGHT
    ) else log_error("jump rose above its height");

    a_airborne: assert property (@(posedge clk)
        chk_jump && (pos[0].y != game_pkg::SPAWN_Y) |-> sprite[0].airborne
    ) else log_error("airborne clear while off the floor");

    a_land: assert property (@(posedge clk) chk_land |->
        (pos[0].y == game_pkg::SPAWN_Y) && !sprite[0].airborne &&
        (apex_y == game_pkg::SPAWN_Y - game_pkg::JUMP_HEIGHT)
    ) else log_error("jump did not reach full height and land");

    a_crash_rise: assert property (@(posedge clk) disable iff (rst)
        chk_crash && !restart &&
        (int'(pos[1].x) - int'(pos[0].x) < game_pkg::PLAYER_W) |=> game_over
    ) else log_error("game_over late after players touched");

    a_crash_cause: assert property (@(posedge clk) disable iff (rst)
        chk_crash && $rose(game_over) |->
            $past(int'(pos[1].x) - int'(pos[0].x) < game_pkg::PLAYER_W)
    ) else log_error("game_over rose without an overlap");

    a_frozen: assert property (@(posedge clk) disable iff (rst)
        chk_crash && game_over && !restart |=> $stable(pos)
    ) else log_error("player moved during game over");

    a_respawn: assert property (@(posedge clk) chk_respawn |->
        players_at_spawn(pos) && !game_over
    ) else log_error("restart did not bring players back to spawn");

    // ------------------------------
    // tests
    // ------------------------------
    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
    endtask

    task automatic reset_values();
        int errs;
        errs = err_cnt;
        chk_spawn = 1'b1;
        @(negedge clk);
        chk_spawn = 1'b0;
        finish_test("reset values", errs);
    endtask

    task automatic walk_right();
        int errs;
        errs = err_cnt;
        buttons[0].right = 1'b1;
        chk_right = 1'b1;
        // already walking before the measured stretch
        repeat (4 * TICK_DIV) @(negedge clk);
        walk_x0 = pos[0].x;
        repeat (WALK_K * TICK_DIV) @(negedge clk);
        chk_walk_len = 1'b1;
        @(negedge clk);
        chk_walk_len = 1'b0;
        chk_right = 1'b0;
        buttons[0].right = 1'b0;
        repeat (2 * TICK_DIV) @(negedge clk);
        finish_test("walk right", errs);
    endtask

    task automatic left_wall();
        int errs;
        int n;
        int burst;
        int gap;
        errs = err_cnt;
        buttons[0].left = 1'b1;
        chk_both = 1'b1;
        n = 0;
        // player 1 gets random bursts of both directions
        while (n < LEFT_TICKS * TICK_DIV) begin
            burst = 1 + ($unsigned($random(seed)) % 8);
            gap   = 1 + ($unsigned($random(seed)) % 4);
            buttons[1].left  = 1'b1;
            buttons[1].right = 1'b1;
            repeat (burst) @(negedge clk);
            buttons[1] = '0;
            repeat (gap) @(negedge clk);
            n += burst + gap;
        end
        chk_wall = 1'b1;
        repeat (WALL_TICKS * TICK_DIV) @(negedge clk);
        chk_wall = 1'b0;
        chk_both = 1'b0;
        buttons[0].left = 1'b0;
        repeat (2 * TICK_DIV) @(negedge clk);
        finish_test("left wall and direction conflict", errs);
    endtask

    task automatic jump_arc();
        int  errs;
        int  n;
        logic rose;
        errs   = err_cnt;
        apex_y = game_pkg::SPAWN_Y;
        rose   = 1'b0;
        chk_jump = 1'b1;
        buttons[0].jump = 1'b1;
        repeat (2 * TICK_DIV) @(negedge clk);
        buttons[0].jump = 1'b0;
        n = 0;
        while ((n < JUMP_TICKS * TICK_DIV) &&
               !(rose && (pos[0].y == game_pkg::SPAWN_Y) && !sprite[0].airborne)) begin
            @(negedge clk);
            if (pos[0].y != game_pkg::SPAWN_Y) begin
                rose = 1'b1;
            end
            if (int'(pos[0].y) < apex_y) begin
                apex_y = pos[0].y;
            end
            n++;
        end
        if (!rose || (pos[0].y != game_pkg::SPAWN_Y)) begin
            note_failure("player 0 did not leave the floor and land again in time");
        end
        chk_land = 1'b1;
        @(negedge clk);
        chk_land = 1'b0;
        chk_jump = 1'b0;
        finish_test("jump arc", errs);
    endtask

    task automatic collision_restart();
        int errs;
        int n;
        errs = err_cnt;
        pulse_restart();
        chk_crash = 1'b1;
        buttons[0].right = 1'b1;
        n = 0;
        while (!game_over && (n < CRASH_TICKS * TICK_DIV)) begin
            @(negedge clk);
            n++;
        end
        if (!game_over) begin
            note_failure("game over never came after player 0 walked into player 1");
        end
        repeat (FREEZE_TICKS * TICK_DIV) @(negedge clk);
        buttons[0] = '0;
        repeat (2) @(negedge clk);
        pulse_restart();
        chk_respawn = 1'b1;
        @(negedge clk);
        chk_respawn = 1'b0;
        chk_crash = 1'b0;
        @(negedge clk);
        finish_test("collision and restart", errs);
    endtask

    initial begin
        seed    = 64702;
        rst     = 1'b1;
        restart = 1'b0;
        buttons = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        reset_values();
        walk_right();
        left_wall();
        jump_arc();
        collision_restart();
        repeat (4) @(negedge clk);
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from the test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== verilog.f ====
source/game_pkg.sv
source/input_conditioner.sv
source/player_move_ctrl.sv
source/scene_collector.sv
source/game_top.sv
tests/tb_clock_gen.sv
tests/game_tb.sv
